// File: source/cp0_pkg.sv
`default_nettype none

package cp0_pkg;

    // ----------------------------------------
    // Widths
    // ----------------------------------------
    localparam int CP0_ADDR_W = 8;
    localparam int CP0_DATA_W = 32;

    // Register address is {regnum, sel}, all at select 0
    localparam logic [CP0_ADDR_W-1:0] ADDR_BADVADDR = 8'd64;
    localparam logic [CP0_ADDR_W-1:0] ADDR_COUNT    = 8'd72;
    localparam logic [CP0_ADDR_W-1:0] ADDR_COMPARE  = 8'd88;
    localparam logic [CP0_ADDR_W-1:0] ADDR_STATUS   = 8'd96;
    localparam logic [CP0_ADDR_W-1:0] ADDR_CAUSE    = 8'd104;
    localparam logic [CP0_ADDR_W-1:0] ADDR_EPC      = 8'd112;
    localparam logic [CP0_ADDR_W-1:0] ADDR_PRID     = 8'd120;
    localparam logic [CP0_ADDR_W-1:0] ADDR_CONFIG0  = 8'd128;

    // ----------------------------------------
    // Exception codes
    // ----------------------------------------
    localparam logic [4:0] EXC_INT     = 5'h00;
    localparam logic [4:0] EXC_MOD     = 5'h01;
    localparam logic [4:0] EXC_TLBL    = 5'h02;
    localparam logic [4:0] EXC_TLBS    = 5'h03;
    localparam logic [4:0] EXC_ADEL    = 5'h04;
    localparam logic [4:0] EXC_ADES    = 5'h05;
    localparam logic [4:0] EXC_CPU     = 5'h0b;
    // Private codes, never seen by software
    localparam logic [4:0] EXC_ERET    = 5'h18;
    localparam logic [4:0] EXC_REFETCH = 5'h19;

    // ----------------------------------------
    // Field positions and masks
    // ----------------------------------------
    localparam int STATUS_EXL_BIT = 1;
    localparam int CAUSE_BD_BIT   = 31;
    localparam int CAUSE_TI_BIT   = 30;
    localparam int CAUSE_CE_HI    = 29;
    localparam int CAUSE_CE_LO    = 28;
    // IP7..IP2 come from hardware, IP1..IP0 from software
    localparam int CAUSE_IP_HI    = 15;
    localparam int CAUSE_IP_HW_LO = 10;
    localparam int CAUSE_EXC_HI   = 6;
    localparam int CAUSE_EXC_LO   = 2;

    // CU0, BEV, IM, UM, EXL, IE
    localparam logic [CP0_DATA_W-1:0] STATUS_WMASK = 32'h1040_ff13;
    localparam logic [CP0_DATA_W-1:0] STATUS_RESET = 32'h0040_0000;
    // IV and the two software interrupt bits
    localparam logic [CP0_DATA_W-1:0] CAUSE_WMASK  = 32'h0080_0300;

    // Compare parked far from Count so no tick fires out of reset
    localparam logic [CP0_DATA_W-1:0] COMPARE_RESET = 32'hffff_ffff;

    localparam logic [CP0_DATA_W-1:0] PRID_VALUE    = 32'h0001_8000;
    // M = 1, MT = 1 (standard TLB), K0 = 3 (cacheable)
    localparam logic [CP0_DATA_W-1:0] CONFIG0_VALUE = 32'h8000_0083;

    // Either slot targets addr this cycle
    function automatic logic slot_write_hit(
        input logic                  wr0_en,
        input logic [CP0_ADDR_W-1:0] wr0_addr,
        input logic                  wr1_en,
        input logic [CP0_ADDR_W-1:0] wr1_addr,
        input logic [CP0_ADDR_W-1:0] addr
    );
        return (wr0_en && (wr0_addr == addr)) || (wr1_en && (wr1_addr == addr));
    endfunction

    // Slot 1 is the younger instruction, so its data wins
    function automatic logic [CP0_DATA_W-1:0] slot_write_data(
        input logic                  wr1_en,
        input logic [CP0_ADDR_W-1:0] wr1_addr,
        input logic [CP0_DATA_W-1:0] wr0_data,
        input logic [CP0_DATA_W-1:0] wr1_data,
        input logic [CP0_ADDR_W-1:0] addr
    );
        return (wr1_en && (wr1_addr == addr)) ? wr1_data : wr0_data;
    endfunction

endpackage

`default_nettype wire

// File: source/cp0_timer.sv
`timescale 1ns/1ps
`default_nettype none

module cp0_timer import cp0_pkg::*; (
    input  wire logic                  clk,
    input  wire logic                  reset_i,
    input  wire logic                  wr0_en_i,
    input  wire logic [CP0_ADDR_W-1:0] wr0_addr_i,
    input  wire logic [CP0_DATA_W-1:0] wr0_data_i,
    input  wire logic                  wr1_en_i,
    input  wire logic [CP0_ADDR_W-1:0] wr1_addr_i,
    input  wire logic [CP0_DATA_W-1:0] wr1_data_i,
    output logic      [CP0_DATA_W-1:0] count_o,
    output logic      [CP0_DATA_W-1:0] compare_o,
    output logic                       timer_irq_o
);

    logic                  half_tick;
    logic [CP0_DATA_W-1:0] count_q;
    logic [CP0_DATA_W-1:0] compare_q;
    logic                  count_wr;
    logic                  compare_wr;
    logic [CP0_DATA_W-1:0] wdata_count;
    logic [CP0_DATA_W-1:0] wdata_compare;

    // Software writes from either issue slot
    assign count_wr      = slot_write_hit(wr0_en_i, wr0_addr_i, wr1_en_i, wr1_addr_i, ADDR_COUNT);
    assign compare_wr    = slot_write_hit(wr0_en_i, wr0_addr_i, wr1_en_i, wr1_addr_i,
                                          ADDR_COMPARE);
    assign wdata_count   = slot_write_data(wr1_en_i, wr1_addr_i, wr0_data_i, wr1_data_i,
                                           ADDR_COUNT);
    assign wdata_compare = slot_write_data(wr1_en_i, wr1_addr_i, wr0_data_i, wr1_data_i,
                                           ADDR_COMPARE);

    // Count runs at half the core clock
    always_ff @(posedge clk) begin
        if (reset_i) begin
            half_tick <= 1'b0;
            count_q   <= '0;
        end else begin
            half_tick <= ~half_tick;
            if (count_wr) begin
                count_q <= wdata_count;
            end else if (half_tick) begin
                count_q <= count_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            compare_q <= COMPARE_RESET;
        end else if (compare_wr) begin
            compare_q <= wdata_compare;
        end
    end

    // Sticky timer flag, cleared only by writing Compare
    always_ff @(posedge clk) begin
        if (reset_i || compare_wr) begin
            timer_irq_o <= 1'b0;
        end else if (count_q == compare_q) begin
            timer_irq_o <= 1'b1;
        end
    end

    assign count_o   = count_q;
    assign compare_o = compare_q;

    // Free-running Count never skips a value
    a_count_step: assert property (@(posedge clk) disable iff (reset_i)
        !count_wr |=> (count_q - $past(count_q)) <= 1)
        else $error("Count stepped by more than one");

endmodule

`default_nettype wire

// File: source/cp0_exception_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module cp0_exception_ctrl import cp0_pkg::*; (
    input  wire logic                  clk,
    input  wire logic                  reset_i,
    input  wire logic [5:0]            int_i,
    input  wire logic                  timer_irq_i,
    input  wire logic                  wr0_en_i,
    input  wire logic [CP0_ADDR_W-1:0] wr0_addr_i,
    input  wire logic [CP0_DATA_W-1:0] wr0_data_i,
    input  wire logic                  wr1_en_i,
    input  wire logic [CP0_ADDR_W-1:0] wr1_addr_i,
    input  wire logic [CP0_DATA_W-1:0] wr1_data_i,
    input  wire logic                  exc_valid_i,
    input  wire logic [4:0]            exc_code_i,
    input  wire logic [CP0_DATA_W-1:0] exc_pc_i,
    input  wire logic [CP0_DATA_W-1:0] exc_badaddr_i,
    input  wire logic                  exc_delay_slot_i,
    input  wire logic                  exc_cop_unit_i,
    output logic      [CP0_DATA_W-1:0] status_o,
    output logic      [CP0_DATA_W-1:0] cause_o,
    output logic      [CP0_DATA_W-1:0] epc_o,
    output logic      [CP0_DATA_W-1:0] badvaddr_o
);

    logic [CP0_DATA_W-1:0] status_q, status_d;
    logic [CP0_DATA_W-1:0] cause_q, cause_d;
    logic [CP0_DATA_W-1:0] epc_q;
    logic [CP0_DATA_W-1:0] badvaddr_q;

    logic exc_ret;
    logic exc_refetch;
    logic exc_entry;
    logic exc_first;
    logic exc_addr_fault;
    logic exc_cpu;

    logic status_wr;
    logic cause_wr;
    logic epc_wr;

    // ----------------------------------------
    // Strobe classification
    // ----------------------------------------
    assign exc_ret     = exc_valid_i && (exc_code_i == EXC_ERET);
    assign exc_refetch = exc_valid_i && (exc_code_i == EXC_REFETCH);
    assign exc_entry   = exc_valid_i && !exc_ret && !exc_refetch;
    // Nested entries keep the state of the outer one
    assign exc_first   = exc_entry && !status_q[STATUS_EXL_BIT];

    // Address and TLB faults report the faulting address
    assign exc_addr_fault = exc_entry && ((exc_code_i == EXC_ADEL) || (exc_code_i == EXC_ADES)
        || (exc_code_i == EXC_TLBL) || (exc_code_i == EXC_TLBS) || (exc_code_i == EXC_MOD));
    assign exc_cpu = exc_entry && (exc_code_i == EXC_CPU);

    assign status_wr = slot_write_hit(wr0_en_i, wr0_addr_i, wr1_en_i, wr1_addr_i, ADDR_STATUS);
    assign cause_wr  = slot_write_hit(wr0_en_i, wr0_addr_i, wr1_en_i, wr1_addr_i, ADDR_CAUSE);
    assign epc_wr    = slot_write_hit(wr0_en_i, wr0_addr_i, wr1_en_i, wr1_addr_i, ADDR_EPC);

    // ----------------------------------------
    // Status
    // ----------------------------------------
    always_comb begin
        status_d = status_q;
        if (status_wr) begin
            status_d = (status_q & ~STATUS_WMASK)
                     | (slot_write_data(wr1_en_i, wr1_addr_i, wr0_data_i, wr1_data_i,
                                        ADDR_STATUS) & STATUS_WMASK);
        end
        // Hardware overrides the software write on EXL
        if (exc_ret) begin
            status_d[STATUS_EXL_BIT] = 1'b0;
        end else if (exc_entry) begin
            status_d[STATUS_EXL_BIT] = 1'b1;
        end
    end

    // ----------------------------------------
    // Cause
    // ----------------------------------------
    always_comb begin
        cause_d = cause_q;
        if (cause_wr) begin
            cause_d = (cause_q & ~CAUSE_WMASK)
                    | (slot_write_data(wr1_en_i, wr1_addr_i, wr0_data_i, wr1_data_i,
                                       ADDR_CAUSE) & CAUSE_WMASK);
        end
        // IP7 shares its line with the timer
        cause_d[CAUSE_IP_HI:CAUSE_IP_HW_LO] = {int_i[5] | timer_irq_i, int_i[4:0]};
        if (exc_first) begin
            cause_d[CAUSE_BD_BIT]              = exc_delay_slot_i;
            cause_d[CAUSE_EXC_HI:CAUSE_EXC_LO] = exc_code_i;
        end
        // Only CP1 or CP0 can be the unusable unit here
        if (exc_cpu) begin
            cause_d[CAUSE_CE_HI:CAUSE_CE_LO] = {1'b0, exc_cop_unit_i};
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            status_q <= STATUS_RESET;
            cause_q  <= '0;
        end else begin
            status_q <= status_d;
            cause_q  <= cause_d;
        end
    end

    // EPC points at the branch when the victim sits in its delay slot
    always_ff @(posedge clk) begin
        if (exc_first) begin
            epc_q <= exc_delay_slot_i ? (exc_pc_i - 32'd4) : exc_pc_i;
        end else if (epc_wr) begin
            epc_q <= slot_write_data(wr1_en_i, wr1_addr_i, wr0_data_i, wr1_data_i, ADDR_EPC);
        end
    end

    // Loaded regardless of EXL
    always_ff @(posedge clk) begin
        if (exc_addr_fault) begin
            badvaddr_q <= exc_badaddr_i;
        end
    end

    assign status_o   = status_q;
    // TI is the timer flag itself, no extra stage
    assign cause_o    = cause_q | (CP0_DATA_W'(timer_irq_i) << CAUSE_TI_BIT);
    assign epc_o      = epc_q;
    assign badvaddr_o = badvaddr_q;

    a_nested_keeps: assert property (@(posedge clk) disable iff (reset_i)
        (exc_entry && status_q[STATUS_EXL_BIT] && !epc_wr) |=>
        (epc_q == $past(epc_q))
        && (cause_q[CAUSE_EXC_HI:CAUSE_EXC_LO] == $past(cause_q[CAUSE_EXC_HI:CAUSE_EXC_LO])))
        else $error("Nested exception changed EPC or ExcCode");

    a_eret_clears_exl: assert property (@(posedge clk) disable iff (reset_i)
        exc_ret |=> !status_q[STATUS_EXL_BIT])
        else $error("EXL still set after ERET");

endmodule

`default_nettype wire

// File: source/cp0_read_mux.sv
`timescale 1ns/1ps
`default_nettype none

module cp0_read_mux import cp0_pkg::*; (
    input  wire logic [CP0_ADDR_W-1:0] rd_addr_i,
    input  wire logic [CP0_DATA_W-1:0] badvaddr_i,
    input  wire logic [CP0_DATA_W-1:0] count_i,
    input  wire logic [CP0_DATA_W-1:0] compare_i,
    input  wire logic [CP0_DATA_W-1:0] status_i,
    input  wire logic [CP0_DATA_W-1:0] cause_i,
    input  wire logic [CP0_DATA_W-1:0] epc_i,
    output logic      [CP0_DATA_W-1:0] rd_data_o
);

    // ----------------------------------------
    // Address decode
    // ----------------------------------------
    always_comb begin
        case (rd_addr_i)
            ADDR_BADVADDR: begin
                rd_data_o = badvaddr_i;
            end
            ADDR_COUNT: begin
                rd_data_o = count_i;
            end
            ADDR_COMPARE: begin
                rd_data_o = compare_i;
            end
            ADDR_STATUS: begin
                rd_data_o = status_i;
            end
            ADDR_CAUSE: begin
                rd_data_o = cause_i;
            end
            ADDR_EPC: begin
                rd_data_o = epc_i;
            end
            // Hardwired identification
            ADDR_PRID: begin
                rd_data_o = PRID_VALUE;
            end
            ADDR_CONFIG0: begin
                rd_data_o = CONFIG0_VALUE;
            end
            // Unimplemented registers read as zero
            default: begin
                rd_data_o = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: source/cp0_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module cp0_regfile import cp0_pkg::*; (
    input  wire logic                  clk,
    input  wire logic                  reset_i,
    input  wire logic [5:0]            int_i,
    // Write slots
    input  wire logic                  wr0_en_i,
    input  wire logic [CP0_ADDR_W-1:0] wr0_addr_i,
    input  wire logic [CP0_DATA_W-1:0] wr0_data_i,
    input  wire logic                  wr1_en_i,
    input  wire logic [CP0_ADDR_W-1:0] wr1_addr_i,
    input  wire logic [CP0_DATA_W-1:0] wr1_data_i,
    // Read ports
    input  wire logic [CP0_ADDR_W-1:0] rd0_addr_i,
    input  wire logic [CP0_ADDR_W-1:0] rd1_addr_i,
    output logic      [CP0_DATA_W-1:0] rd0_data_o,
    output logic      [CP0_DATA_W-1:0] rd1_data_o,
    // Exception strobe
    input  wire logic                  exc_valid_i,
    input  wire logic [4:0]            exc_code_i,
    input  wire logic [CP0_DATA_W-1:0] exc_pc_i,
    input  wire logic [CP0_DATA_W-1:0] exc_badaddr_i,
    input  wire logic                  exc_delay_slot_i,
    input  wire logic                  exc_cop_unit_i,
    // Pipeline view
    output logic      [CP0_DATA_W-1:0] status_o,
    output logic      [CP0_DATA_W-1:0] cause_o,
    output logic      [CP0_DATA_W-1:0] epc_o
);

    logic [CP0_DATA_W-1:0] count;
    logic [CP0_DATA_W-1:0] compare;
    logic [CP0_DATA_W-1:0] badvaddr;
    logic                  timer_irq;

    cp0_timer u_timer (
        .clk         (clk),
        .reset_i     (reset_i),
        .wr0_en_i    (wr0_en_i),
        .wr0_addr_i  (wr0_addr_i),
        .wr0_data_i  (wr0_data_i),
        .wr1_en_i    (wr1_en_i),
        .wr1_addr_i  (wr1_addr_i),
        .wr1_data_i  (wr1_data_i),
        .count_o     (count),
        .compare_o   (compare),
        .timer_irq_o (timer_irq)
    );

    cp0_exception_ctrl u_exc (
        .clk              (clk),
        .reset_i          (reset_i),
        .int_i            (int_i),
        .timer_irq_i      (timer_irq),
        .wr0_en_i         (wr0_en_i),
        .wr0_addr_i       (wr0_addr_i),
        .wr0_data_i       (wr0_data_i),
        .wr1_en_i         (wr1_en_i),
        .wr1_addr_i       (wr1_addr_i),
        .wr1_data_i       (wr1_data_i),
        .exc_valid_i      (exc_valid_i),
        .exc_code_i       (exc_code_i),
        .exc_pc_i         (exc_pc_i),
        .exc_badaddr_i    (exc_badaddr_i),
        .exc_delay_slot_i (exc_delay_slot_i),
        .exc_cop_unit_i   (exc_cop_unit_i),
        .status_o         (status_o),
        .cause_o          (cause_o),
        .epc_o            (epc_o),
        .badvaddr_o       (badvaddr)
    );

    // One mux per issue slot
    cp0_read_mux u_rd0 (
        .rd_addr_i  (rd0_addr_i),
        .badvaddr_i (badvaddr),
        .count_i    (count),
        .compare_i  (compare),
        .status_i   (status_o),
        .cause_i    (cause_o),
        .epc_i      (epc_o),
        .rd_data_o  (rd0_data_o)
    );

    cp0_read_mux u_rd1 (
        .rd_addr_i  (rd1_addr_i),
        .badvaddr_i (badvaddr),
        .count_i    (count),
        .compare_i  (compare),
        .status_i   (status_o),
        .cause_i    (cause_o),
        .epc_i      (epc_o),
        .rd_data_o  (rd1_data_o)
    );

endmodule

`default_nettype wire

// File: bench/tb_cp0_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cp0_regfile import cp0_pkg::*; ();

    logic                  clk;
    logic                  reset;
    logic [5:0]            int_lines;
    logic                  wr0_en, wr1_en;
    logic [CP0_ADDR_W-1:0] wr0_addr, wr1_addr, rd0_addr, rd1_addr;
    logic [CP0_DATA_W-1:0] wr0_data, wr1_data, rd0_data, rd1_data;
    logic                  exc_valid, exc_delay_slot, exc_cop_unit;
    logic [4:0]            exc_code;
    logic [CP0_DATA_W-1:0] exc_pc, exc_badaddr;
    logic [CP0_DATA_W-1:0] status, cause, epc;

    // Reference model state
    logic [CP0_DATA_W-1:0] ref_status, ref_cause, ref_epc, ref_badvaddr;
    logic [CP0_DATA_W-1:0] ref_count, ref_compare, exp_cause;
    logic                  ref_ti, ref_half, epc_known, badvaddr_known;
    logic                  exc_entry, exc_return;
    // Top bit set when the expected value is known
    logic [CP0_DATA_W:0]   exp_rd0, exp_rd1;
    logic [15:0]           lfsr;

    cp0_regfile dut (
        .clk              (clk),
        .reset_i          (reset),
        .int_i            (int_lines),
        .wr0_en_i         (wr0_en),
        .wr0_addr_i       (wr0_addr),
        .wr0_data_i       (wr0_data),
        .wr1_en_i         (wr1_en),
        .wr1_addr_i       (wr1_addr),
        .wr1_data_i       (wr1_data),
        .rd0_addr_i       (rd0_addr),
        .rd1_addr_i       (rd1_addr),
        .rd0_data_o       (rd0_data),
        .rd1_data_o       (rd1_data),
        .exc_valid_i      (exc_valid),
        .exc_code_i       (exc_code),
        .exc_pc_i         (exc_pc),
        .exc_badaddr_i    (exc_badaddr),
        .exc_delay_slot_i (exc_delay_slot),
        .exc_cop_unit_i   (exc_cop_unit),
        .status_o         (status),
        .cause_o          (cause),
        .epc_o            (epc)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ----------------------------------------
    // Helpers
    // ----------------------------------------
    // Fibonacci LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
    endfunction

    // One LFSR step per bit
    task automatic take_random(input int nbits, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr  = lfsr_step(lfsr);
            value = {value[30:0], lfsr[0]};
        end
    endtask

    function automatic logic written(input logic [CP0_ADDR_W-1:0] addr);
        return (wr0_en && (wr0_addr == addr)) || (wr1_en && (wr1_addr == addr));
    endfunction

    // Slot 1 wins a collision
    function automatic logic [CP0_DATA_W-1:0] written_value(input logic [CP0_ADDR_W-1:0] addr);
        if (wr1_en && (wr1_addr == addr)) begin
            return wr1_data;
        end
        return wr0_data;
    endfunction

    function automatic logic [CP0_DATA_W:0] expected_read(input logic [CP0_ADDR_W-1:0] addr);
        case (addr)
            ADDR_BADVADDR: return {badvaddr_known, ref_badvaddr};
            ADDR_COUNT:    return {1'b1, ref_count};
            ADDR_COMPARE:  return {1'b1, ref_compare};
            ADDR_STATUS:   return {1'b1, ref_status};
            ADDR_CAUSE:    return {1'b1, exp_cause};
            ADDR_EPC:      return {epc_known, ref_epc};
            ADDR_PRID:     return {1'b1, PRID_VALUE};
            ADDR_CONFIG0:  return {1'b1, CONFIG0_VALUE};
            default:       return {1'b1, 32'h0};
        endcase
    endfunction

    task automatic stop_on_failure(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        stop_on_failure($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
    endtask

    // ----------------------------------------
    // Reference model
    // ----------------------------------------
    assign exc_return = exc_valid && (exc_code == EXC_ERET);
    assign exc_entry  = exc_valid && (exc_code != EXC_ERET) && (exc_code != EXC_REFETCH);
    assign exp_cause  = ref_cause | (CP0_DATA_W'(ref_ti) << CAUSE_TI_BIT);

    always @(posedge clk) begin : model_update
        logic [CP0_DATA_W-1:0] s;
        logic [CP0_DATA_W-1:0] c;
        if (reset) begin
            ref_status     <= STATUS_RESET;
            ref_cause      <= '0;
            ref_ti         <= 1'b0;
            ref_half       <= 1'b0;
            ref_count      <= '0;
            ref_compare    <= COMPARE_RESET;
            epc_known      <= 1'b0;
            badvaddr_known <= 1'b0;
        end else begin
            s = ref_status;
            if (written(ADDR_STATUS)) begin
                s = (s & ~STATUS_WMASK) | (written_value(ADDR_STATUS) & STATUS_WMASK);
            end
            // Strobe beats software on EXL
            if (exc_return) begin
                s[STATUS_EXL_BIT] = 1'b0;
            end else if (exc_entry) begin
                s[STATUS_EXL_BIT] = 1'b1;
            end
            c = ref_cause;
            if (written(ADDR_CAUSE)) begin
                c = (c & ~CAUSE_WMASK) | (written_value(ADDR_CAUSE) & CAUSE_WMASK);
            end
            c[CAUSE_IP_HI:CAUSE_IP_HW_LO] = {int_lines[5] | ref_ti, int_lines[4:0]};
            // First-level entry records where and why
            if (exc_entry && !ref_status[STATUS_EXL_BIT]) begin
                c[CAUSE_BD_BIT]              = exc_delay_slot;
                c[CAUSE_EXC_HI:CAUSE_EXC_LO] = exc_code;
                ref_epc   <= exc_delay_slot ? (exc_pc - 32'd4) : exc_pc;
                epc_known <= 1'b1;
            end else if (written(ADDR_EPC)) begin
                ref_epc   <= written_value(ADDR_EPC);
                epc_known <= 1'b1;
            end
            if (exc_entry && (exc_code == EXC_CPU)) begin
                c[CAUSE_CE_HI:CAUSE_CE_LO] = {1'b0, exc_cop_unit};
            end
            if (exc_entry && (exc_code inside {EXC_MOD, EXC_TLBL, EXC_TLBS, EXC_ADEL,
                                               EXC_ADES})) begin
                ref_badvaddr   <= exc_badaddr;
                badvaddr_known <= 1'b1;
            end
            ref_status <= s;
            ref_cause  <= c;
            // Half-rate Count
            ref_half <= ~ref_half;
            if (written(ADDR_COUNT)) begin
                ref_count <= written_value(ADDR_COUNT);
            end else if (ref_half) begin
                ref_count <= ref_count + 32'd1;
            end
            if (written(ADDR_COMPARE)) begin
                ref_compare <= written_value(ADDR_COMPARE);
                ref_ti      <= 1'b0;
            end else if (ref_count == ref_compare) begin
                ref_ti <= 1'b1;
            end
        end
    end

    always_comb begin
        exp_rd0 = expected_read(rd0_addr);
        exp_rd1 = expected_read(rd1_addr);
    end

    a_status: assert property (@(posedge clk) disable iff (reset) status == ref_status)
        else report_mismatch("status_o", $sampled(status), $sampled(ref_status));
    a_cause: assert property (@(posedge clk) disable iff (reset) cause == exp_cause)
        else report_mismatch("cause_o", $sampled(cause), $sampled(exp_cause));
    a_epc: assert property (@(posedge clk) disable iff (reset) epc_known |-> epc == ref_epc)
        else report_mismatch("epc_o", $sampled(epc), $sampled(ref_epc));
    a_rd0: assert property (@(posedge clk) disable iff (reset)
        exp_rd0[CP0_DATA_W] |-> rd0_data == exp_rd0[CP0_DATA_W-1:0])
        else report_mismatch("rd0_data_o", $sampled(rd0_data), $sampled(exp_rd0[31:0]));
    a_rd1: assert property (@(posedge clk) disable iff (reset)
        exp_rd1[CP0_DATA_W] |-> rd1_data == exp_rd1[CP0_DATA_W-1:0])
        else report_mismatch("rd1_data_o", $sampled(rd1_data), $sampled(exp_rd1[31:0]));

    // ----------------------------------------
    // Stimulus driven on falling edges
    // ----------------------------------------
    task automatic release_inputs();
        int_lines      = '0;
        wr0_en         = 1'b0;
        wr0_addr       = '0;
        wr0_data       = '0;
        wr1_en         = 1'b0;
        wr1_addr       = '0;
        wr1_data       = '0;
        rd0_addr       = '0;
        rd1_addr       = '0;
        exc_valid      = 1'b0;
        exc_code       = '0;
        exc_pc         = '0;
        exc_badaddr    = '0;
        exc_delay_slot = 1'b0;
        exc_cop_unit   = 1'b0;
    endtask

    task automatic write_slots(input logic en0, input logic [7:0] a0, input logic [31:0] d0,
                               input logic en1, input logic [7:0] a1, input logic [31:0] d1);
        wr0_en   = en0;
        wr0_addr = a0;
        wr0_data = d0;
        wr1_en   = en1;
        wr1_addr = a1;
        wr1_data = d1;
        @(negedge clk);
        wr0_en = 1'b0;
        wr1_en = 1'b0;
    endtask

    task automatic read_ports(input logic [7:0] a0, input logic [7:0] a1);
        rd0_addr = a0;
        rd1_addr = a1;
        @(negedge clk);
    endtask

    task automatic raise_exception(input logic [4:0] code, input logic [31:0] pc,
                                   input logic [31:0] badaddr, input logic delay,
                                   input logic cop);
        exc_valid      = 1'b1;
        exc_code       = code;
        exc_pc         = pc;
        exc_badaddr    = badaddr;
        exc_delay_slot = delay;
        exc_cop_unit   = cop;
        @(negedge clk);
        exc_valid = 1'b0;
    endtask

    initial begin : stimulus
        logic [31:0]           r0, r1, pc, c1, c2;
        logic [CP0_ADDR_W-1:0] targets [4];
        int                    waited;
        targets = '{ADDR_STATUS, ADDR_CAUSE, ADDR_EPC, ADDR_COMPARE};
        lfsr  = 16'd12;
        reset = 1'b1;
        release_inputs();
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // Constants and unmapped addresses
        read_ports(ADDR_PRID, ADDR_CONFIG0);
        read_ports(ADDR_CONFIG0, ADDR_PRID);
        read_ports(ADDR_STATUS, ADDR_CAUSE);
        read_ports(8'h05, 8'hff);

        // Single-slot writes then a same-register collision
        for (int round = 0; round < 6; round++) begin
            foreach (targets[k]) begin
                take_random(32, r0);
                take_random(1, r1);
                write_slots(!r1[0], targets[k], r0, r1[0], targets[k], r0);
                read_ports(targets[k], targets[k]);
                take_random(32, r1);
                write_slots(1'b1, targets[k], r0, 1'b1, targets[k], r1);
                read_ports(targets[k], targets[k]);
            end
        end

        // Entry out of a delay slot with EXL clear
        write_slots(1'b1, ADDR_STATUS, 32'h0, 1'b0, '0, '0);
        take_random(32, pc);
        take_random(32, r0);
        raise_exception(EXC_ADEL, {pc[31:2], 2'b00}, r0, 1'b0, 1'b0);
        read_ports(ADDR_EPC, ADDR_BADVADDR);
        raise_exception(EXC_ERET, '0, '0, 1'b0, 1'b0);
        // Entry in a delay slot with CP1 unusable
        take_random(32, pc);
        raise_exception(EXC_CPU, {pc[31:2], 2'b00}, '0, 1'b1, 1'b1);
        read_ports(ADDR_EPC, ADDR_CAUSE);
        // Nested entries while EXL is set
        take_random(32, pc);
        take_random(32, r0);
        raise_exception(EXC_ADES, pc, r0, 1'b0, 1'b0);
        read_ports(ADDR_EPC, ADDR_BADVADDR);
        raise_exception(EXC_CPU, pc, '0, 1'b1, 1'b0);
        read_ports(ADDR_CAUSE, ADDR_STATUS);

        // Return and refetch
        raise_exception(EXC_ERET, pc, '0, 1'b0, 1'b0);
        read_ports(ADDR_STATUS, ADDR_EPC);
        raise_exception(EXC_REFETCH, pc, ~r0, 1'b1, 1'b1);
        read_ports(ADDR_CAUSE, ADDR_EPC);
        // Read-only and unmapped targets ignore writes
        write_slots(1'b1, ADDR_PRID, r0, 1'b1, ADDR_BADVADDR, pc);
        read_ports(ADDR_PRID, ADDR_BADVADDR);
        write_slots(1'b1, ADDR_CONFIG0, r0, 1'b1, 8'h3c, pc);
        read_ports(ADDR_CONFIG0, 8'h3c);

        // Count rate after a load
        take_random(31, r0);
        write_slots(1'b1, ADDR_COUNT, r0, 1'b0, '0, '0);
        rd0_addr = ADDR_COUNT;
        @(negedge clk);
        c1 = rd0_data;
        repeat (2) @(negedge clk);
        c2 = rd0_data;
        if (c2 != c1 + 32'd1) begin
            report_mismatch("rd0_data_o", c2, c1 + 32'd1);
        end

        // Compare just ahead of Count
        write_slots(1'b1, ADDR_COMPARE, c2 + 32'd3, 1'b0, '0, '0);
        rd0_addr = ADDR_CAUSE;
        waited   = 0;
        while (!(cause[CAUSE_TI_BIT] && cause[CAUSE_IP_HI]) && (waited < 40)) begin
            @(negedge clk);
            waited++;
        end
        if (!(cause[CAUSE_TI_BIT] && cause[CAUSE_IP_HI])) begin
            stop_on_failure("Timed out waiting for TI and IP7 in Cause");
        end

        // Interrupt lines with TI set and then cleared by a Compare write
        for (int i = 0; i < 8; i++) begin
            if (i == 4) begin
                write_slots(1'b1, ADDR_COMPARE, c2 - 32'd16, 1'b0, '0, '0);
            end
            take_random(6, r0);
            int_lines = r0[5:0];
            read_ports(ADDR_CAUSE, ADDR_COMPARE);
            read_ports(ADDR_CAUSE, ADDR_CAUSE);
        end
        int_lines = '0;
        repeat (3) @(negedge clk);
        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
source/cp0_pkg.sv
source/cp0_timer.sv
source/cp0_exception_ctrl.sv
source/cp0_read_mux.sv
source/cp0_regfile.sv
bench/tb_cp0_regfile.sv

// File: Makefile
TOP := tb_cp0_regfile

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module $(TOP) \
		-Mdir obj_dir -o $(TOP)

run: compile
	@out="$$(./obj_dir/$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir
